// File: conway_uart.f
hdl/life_pkg.sv
hdl/board_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/life_board.sv
hdl/board_printer.sv
hdl/life_ctrl.sv
hdl/conway_uart.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_conway_uart.sv

// File: Makefile
# Verilator build and run of the conway_uart testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_conway_uart
FILELIST  := conway_uart.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := *** TEST PASSED ***

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_conway_uart.sv
// assumes a 10 MHz clk and 115200 baud; the model tracks board and lfsr from reset onward
`timescale 1ns/1ps
`default_nettype none

module tb_conway_uart import life_pkg::*; ();

  localparam int byte_clks      = 10 * clks_per_bit; // one 8N1 character
  localparam int clk_period_ns  = 100;
  localparam int drive_delay_ns = 1;                 // after the rising edge
  localparam int reset_cycles   = 10;
  localparam int silence_bytes  = 20;
  localparam int budget_bytes   = 100;               // watchdog share per entry
  localparam int max_gap_clks   = 200;

  wire  clk;
  wire  boot_reset;
  wire  tx;
  logic rx;

  // command table, one row per index
  string test_name [$];
  byte_t test_cmd [$];
  bit    test_frame [$];
  int    table_size = 0;

  board_t model_board;
  lfsr_t  model_lfsr;

  tb_clock_gen clock_gen_inst (.clk, .boot_reset);

  conway_uart conway_uart_inst (.clk, .boot_reset, .rx, .tx);

  tb_checker checker_inst (.clk, .boot_reset, .tx);

  task automatic add_test(input string name, input byte_t cmd, input bit frame);
    test_name.push_back(name);
    test_cmd.push_back(cmd);
    test_frame.push_back(frame);
  endtask

  // 8N1 onto rx, every edge a fixed delay after posedge
  task automatic send_byte(input byte_t b);
    logic [9:0] bits;
    int         i;
    bits = {1'b1, b, 1'b0}; // stop, data, start
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #drive_delay_ns rx = bits[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
  endtask

  // cell gets lfsr bit 0, then one shift with taps 15 13 12 10
  function automatic void model_fill();
    int n;
    for (n = 0; n < board_cells; n++) begin
      model_board[n] = model_lfsr[0];
      model_lfsr = {model_lfsr[14:0],
                    model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10]};
    end
  endfunction

  function automatic int count_neighbors(input board_t b, input int r, input int c);
    int n;
    int dr;
    int dc;
    n = 0;
    for (dr = -1; dr <= 1; dr++) begin
      for (dc = -1; dc <= 1; dc++) begin
        if (dr != 0 || dc != 0)
          n += b[((r + dr) & 7) * board_width + ((c + dc) & 7)]; // torus wrap
      end
    end
    return n;
  endfunction

  function automatic void model_step();
    board_t nxt;
    int     r;
    int     c;
    int     n;
    for (r = 0; r < 8; r++) begin
      for (c = 0; c < board_width; c++) begin
        n = count_neighbors(model_board, r, c);
        nxt[r * board_width + c] = (n == 3) || (model_board[r * board_width + c] && n == 2);
      end
    end
    model_board = nxt; // whole board replaced at once
  endfunction

  // home escape, then rows of 'O' and space, each closed by CR LF
  task automatic build_expected();
    int r;
    int c;
    int pos;
    checker_inst.exp_frame[0] = 8'h1b;
    checker_inst.exp_frame[1] = "[";
    checker_inst.exp_frame[2] = ";";
    checker_inst.exp_frame[3] = "H";
    pos = 4;
    for (r = 0; r < 8; r++) begin
      for (c = 0; c < board_width; c++) begin
        checker_inst.exp_frame[pos] = model_board[r * board_width + c] ? "O" : " ";
        pos++;
      end
      checker_inst.exp_frame[pos] = 8'h0d;
      checker_inst.exp_frame[pos + 1] = 8'h0a;
      pos += 2;
    end
  endtask

  initial begin
    int i;
    int k;
    int steps;
    int gap;
    rx          = 1'b1; // idle line
    model_board = '0;
    model_lfsr  = lfsr_seed;
    void'($urandom(32'hc99c_d46b));
    add_test("random_fill", cmd_random, 1'b1);
    add_test("step_wrap", cmd_step, 1'b1);
    steps = 1 + ($urandom % 4);
    for (k = 0; k < steps; k++) add_test($sformatf("step_run_%0d", k), cmd_step, 1'b1);
    add_test("ignore_x", "x", 1'b0);
    add_test("ignore_space", " ", 1'b0);
    add_test("ignore_cr", 8'h0d, 1'b0);
    add_test("step_after_junk", cmd_step, 1'b1);
    add_test("random_refill", cmd_random, 1'b1);
    add_test("step_after_refill", cmd_step, 1'b1);
    table_size = test_name.size();
    @(negedge boot_reset);
    checker_inst.check_silence("idle_after_reset", silence_bytes);
    for (i = 0; i < table_size; i++) begin
      gap = $urandom % max_gap_clks;
      repeat (gap) @(posedge clk);
      send_byte(test_cmd[i]);
      if (test_cmd[i] == cmd_random) model_fill();
      else if (test_cmd[i] == cmd_step) model_step();
      if (test_frame[i]) begin
        build_expected();
        checker_inst.check_frame(test_name[i]);
      end else begin
        checker_inst.check_silence(test_name[i], silence_bytes);
      end
    end
    $display("summary: %0d tests passed, %0d failed",
             checker_inst.pass_count, checker_inst.fail_count);
    if (checker_inst.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // one spare entry covers the idle check after reset
  initial begin : watchdog
    longint limit;
    wait (table_size > 0);
    limit = longint'(table_size + 1) * budget_bytes * byte_clks * clk_period_ns
            + reset_cycles * clk_period_ns;
    #(limit);
    $display("watchdog: run did not finish within %0d ns", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_checker.sv
// decodes tx at clks_per_bit, sampling on the falling clk edge; expects 84-byte frames
`timescale 1ns/1ps
`default_nettype none

module tb_checker import life_pkg::*; (
  input wire clk,
  input wire boot_reset,
  input wire tx
);

  localparam int frame_len        = 84; // 4 home bytes + 8 rows of 10
  localparam int frame_wait_bytes = 90; // generous bound on frame latency

  byte_t rx_q [$];              // decoded bytes not yet checked
  byte_t exp_frame [frame_len]; // written by the testbench top
  int    pass_count = 0;
  int    fail_count = 0;

  // serial decoder, mid-bit sampling
  initial begin : decode_tx
    byte_t b;
    int    i;
    @(negedge boot_reset);
    forever begin
      @(negedge tx);                                // start edge
      repeat (clks_per_bit / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        $display("checker: start bit on tx did not hold at %0t", $time);
        fail_count++;
      end else begin
        for (i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          b[i] = tx;                                // lsb first
        end
        repeat (clks_per_bit) @(negedge clk);       // middle of stop bit
        if (tx !== 1'b1) begin
          $display("checker: stop bit on tx was low at %0t, byte dropped", $time);
          fail_count++;
        end else begin
          rx_q.push_back(b);
        end
      end
    end
  end

  // waits for a whole frame, then compares it with exp_frame
  task automatic check_frame(input string name);
    int    waited;
    int    i;
    int    mismatches;
    int    first_pos;
    byte_t first_exp;
    byte_t first_got;
    byte_t got;
    waited     = 0;
    mismatches = 0;
    first_pos  = 0;
    first_exp  = '0;
    first_got  = '0;
    while (rx_q.size() < frame_len && waited < frame_wait_bytes * 10 * clks_per_bit) begin
      @(negedge clk);
      waited++;
    end
    if (rx_q.size() < frame_len) begin
      $display("%s: frame missing, only %0d of %0d bytes arrived in time",
               name, rx_q.size(), frame_len);
      rx_q.delete();
      fail_count++;
    end else begin
      for (i = 0; i < frame_len; i++) begin
        got = rx_q.pop_front();
        if (got !== exp_frame[i]) begin
          if (mismatches == 0) begin // report the first one, count the rest
            first_pos = i;
            first_exp = exp_frame[i];
            first_got = got;
          end
          mismatches++;
        end
      end
      if (mismatches == 0) begin
        $display("passed %s", name);
        pass_count++;
      end else begin
        $display("FAILED %s: byte %0d expected 8'h%02h actual 8'h%02h (%0d bytes differ)",
                 name, first_pos, first_exp, first_got, mismatches);
        fail_count++;
      end
    end
  endtask

  // no byte may appear for byte_times byte periods
  task automatic check_silence(input string name, input int byte_times);
    repeat (byte_times * 10 * clks_per_bit) @(negedge clk);
    if (rx_q.size() != 0) begin
      $display("%s: unexpected output, %0d bytes sent while no frame was due",
               name, rx_q.size());
      rx_q.delete();
      fail_count++;
    end else if (tx !== 1'b1) begin
      $display("%s: tx line is not idle high", name);
      fail_count++;
    end else begin
      $display("passed %s", name);
      pass_count++;
    end
  endtask

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// free-running 10 MHz clock; reset is released 1 ns after a rising edge, never on one
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic boot_reset
);

  localparam int half_period_ns   = 50; // 100 ns period
  localparam int reset_cycles     = 10;
  localparam int release_delay_ns = 1;

  initial begin
    clk = 1'b0;
    forever #half_period_ns clk = ~clk;
  end

  initial begin
    boot_reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #release_delay_ns boot_reset = 1'b0; // clear of the edge
  end

endmodule

`default_nettype wire

// File: hdl/conway_uart.sv
// rx and tx are 115200 8N1 at a 10 MHz clk; rx must already be idle high when reset drops
`timescale 1ns/1ps
`default_nettype none

module conway_uart import life_pkg::*; (
  input  wire  clk,
  input  wire  boot_reset,
  input  wire  rx,  // serial in
  output logic tx   // serial out
);

  byte_t rx_data, tx_data;
  logic  rx_valid, tx_start, tx_busy;
  logic  print_start, print_done;

  board_if brd ();

  uart_rx uart_rx_inst (.clk, .boot_reset, .rx, .rx_data, .rx_valid);

  life_ctrl life_ctrl_inst (.clk, .boot_reset, .rx_data, .rx_valid, .brd(brd.ctrl),
                            .print_start, .print_done);

  life_board life_board_inst (.clk, .boot_reset, .brd(brd.engine));

  board_printer board_printer_inst (.clk, .boot_reset, .print_start, .print_done,
                                    .brd(brd.reader), .tx_start, .tx_data, .tx_busy);

  uart_tx uart_tx_inst (.clk, .boot_reset, .tx_start, .tx_data, .tx, .tx_busy);

endmodule

`default_nettype wire

// File: hdl/life_ctrl.sv
// one command at a time; characters received while busy are dropped, not queued
`timescale 1ns/1ps
`default_nettype none

module life_ctrl import life_pkg::*; (
  input  wire        clk,
  input  wire        boot_reset,
  input  wire byte_t rx_data,
  input  wire        rx_valid,
  board_if.ctrl      brd,
  output logic       print_start,
  input  wire        print_done
);

  ctrl_state_t state;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state          <= ctrl_idle;
      brd.fill_start <= 1'b0;
      brd.step_start <= 1'b0;
      print_start    <= 1'b0;
    end else begin
      brd.fill_start <= 1'b0; // all strobes one cycle
      brd.step_start <= 1'b0;
      print_start    <= 1'b0;
      case (state)
        ctrl_idle: if (rx_valid) begin
          if (rx_data == cmd_random) begin
            brd.fill_start <= 1'b1;
            state          <= ctrl_fill;
          end else if (rx_data == cmd_step) begin
            brd.step_start <= 1'b1;
            state          <= ctrl_update;
          end // anything else ignored
        end
        ctrl_fill, ctrl_update: if (brd.done) begin
          print_start <= 1'b1; // show the result of either action
          state       <= ctrl_print;
        end
        default: if (print_done) state <= ctrl_idle; // ctrl_print
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/board_printer.sv
// print_start is ignored mid-frame; the board must not change until print_done
`timescale 1ns/1ps
`default_nettype none

module board_printer import life_pkg::*; (
  input  wire     clk,
  input  wire     boot_reset,
  input  wire     print_start,
  output logic    print_done,
  board_if.reader brd,
  output logic    tx_start,
  output byte_t   tx_data,
  input  wire     tx_busy
);

  print_state_t state;
  print_state_t ret_state;  // where to go once the byte is out
  logic         active;     // frame in progress
  logic         seen_busy;  // tx_busy went high since our strobe
  logic         lf_phase;   // 0 = CR next, 1 = LF next
  logic         last_byte;  // final LF of the frame
  logic [$clog2(home_seq_len)-1:0] home_idx;
  cell_index_t  cursor;     // next cell to print

  assign brd.rd_index = cursor;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state      <= prt_home;
      ret_state  <= prt_home;
      active     <= 1'b0;
      seen_busy  <= 1'b0;
      lf_phase   <= 1'b0;
      last_byte  <= 1'b0;
      home_idx   <= '0;
      cursor     <= '0;
      tx_start   <= 1'b0;
      print_done <= 1'b0;
    end else begin
      tx_start   <= 1'b0;
      print_done <= 1'b0;
      if (!active) begin
        if (print_start) begin
          active    <= 1'b1;
          state     <= prt_home;
          home_idx  <= '0;
          cursor    <= '0;
          lf_phase  <= 1'b0;
          last_byte <= 1'b0;
        end
      end else begin
        // every send state strobes the uart then parks in wait_busy
        case (state)
          prt_home: begin
            tx_data   <= home_seq[home_idx];
            ret_state <= (home_idx == home_seq_len - 1) ? prt_cell : prt_home;
            home_idx  <= home_idx + 1'b1;
          end
          prt_cell: begin
            tx_data   <= brd.rd_cell ? char_alive : char_dead;
            ret_state <= (cursor[log_width-1:0] == log_width'(board_width - 1)) ?
                         prt_line_end : prt_cell;     // row done after column 7
            cursor    <= cursor + 1'b1;
          end
          prt_line_end: begin
            tx_data   <= lf_phase ? char_lf : char_cr;
            ret_state <= lf_phase ? prt_cell : prt_line_end;
            last_byte <= lf_phase && (cursor == '0); // cursor wrapped past cell 63
            lf_phase  <= ~lf_phase;
          end
          default: begin // prt_wait_busy
            if (tx_busy) begin
              seen_busy <= 1'b1;
            end else if (seen_busy) begin
              if (last_byte) begin
                active     <= 1'b0;
                print_done <= 1'b1;
              end else begin
                state <= ret_state;
              end
            end
          end
        endcase
        if (state != prt_wait_busy) begin
          tx_start  <= 1'b1;
          seen_busy <= 1'b0;
          state     <= prt_wait_busy;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/life_board.sv
// start strobes are only honoured when idle; rd_cell shows the current board, never next
`timescale 1ns/1ps
`default_nettype none

module life_board import life_pkg::*; (
  input  wire     clk,
  input  wire     boot_reset,
  board_if.engine brd
);

  engine_state_t state;
  board_t        current;  // displayed generation
  board_t        next;     // generation under construction
  lfsr_t         lfsr;
  cell_index_t   idx;      // cell being filled or evaluated
  logic [3:0]    nb_sel;   // 0..7 neighbor, 8 = apply rule
  logic [3:0]    nb_count; // live neighbors so far

  logic [log_height-1:0] row, nb_row;
  logic [log_width-1:0]  col, nb_col;
  cell_index_t           nb_index;
  logic                  lfsr_fb;

  assign brd.rd_cell = current[brd.rd_index];

  assign row      = idx[log_width+log_height-1:log_width];
  assign col      = idx[log_width-1:0];
  assign nb_index = {nb_row, nb_col};
  assign lfsr_fb  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // neighbor offsets; 3-bit arithmetic gives the torus wrap
  always_comb begin
    nb_row = row;
    nb_col = col;
    case (nb_sel)
      4'd0, 4'd1, 4'd2: nb_row = row - 1'b1; // row above
      4'd5, 4'd6, 4'd7: nb_row = row + 1'b1; // row below
      default: ;
    endcase
    case (nb_sel)
      4'd0, 4'd3, 4'd5: nb_col = col - 1'b1; // left
      4'd2, 4'd4, 4'd7: nb_col = col + 1'b1; // right
      default: ;
    endcase
  end

  // fill writes current directly; an update builds next cell by cell, then copies it whole
  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state    <= eng_idle;
      current  <= '0;        // all dead
      lfsr     <= lfsr_seed;
      idx      <= '0;
      nb_sel   <= '0;
      nb_count <= '0;
      brd.done <= 1'b0;
    end else begin
      brd.done <= 1'b0;
      case (state)
        eng_idle: begin
          idx <= '0;
          if (brd.fill_start)      state <= eng_fill;
          else if (brd.step_start) state <= eng_count;
        end
        eng_fill: begin
          current[idx] <= lfsr[0];          // newest lfsr bit into the cell
          lfsr         <= {lfsr[14:0], lfsr_fb}; // one shift per written cell
          idx          <= idx + 1'b1;
          if (idx == cell_index_t'(board_cells - 1)) begin
            state    <= eng_idle;
            brd.done <= 1'b1;
          end
        end
        eng_count: begin
          if (nb_sel != 4'd8) begin
            nb_count <= nb_count + {3'b000, current[nb_index]};
            nb_sel   <= nb_sel + 1'b1;
          end else begin
            // born on 3, survives on 2 or 3
            next[idx] <= (nb_count == 4'd3) || (current[idx] && nb_count == 4'd2);
            nb_sel    <= '0;
            nb_count  <= '0;
            idx       <= idx + 1'b1;
            if (idx == cell_index_t'(board_cells - 1)) state <= eng_copy;
          end
        end
        default: begin // eng_copy, whole board in one cycle
          current  <= next;
          state    <= eng_idle;
          brd.done <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
// 8N1, tx_start is ignored while tx_busy is high; caller must wait out the frame
`timescale 1ns/1ps
`default_nettype none

module uart_tx import life_pkg::*; (
  input  wire        clk,
  input  wire        boot_reset,
  input  wire        tx_start,
  input  wire byte_t tx_data,
  output logic       tx,
  output logic       tx_busy
);

  logic [9:0] shreg;   // {stop, data, start}, bit 0 on the line
  logic [3:0] bit_cnt; // 0..9
  baud_cnt_t  baud_cnt;

  assign tx = ~tx_busy | shreg[0]; // high when idle

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      tx_busy  <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        shreg    <= {1'b1, tx_data, 1'b0};
        tx_busy  <= 1'b1; // rises the cycle after the strobe
        bit_cnt  <= '0;
        baud_cnt <= '0;
      end
    end else if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
      baud_cnt <= '0;
      shreg    <= {1'b1, shreg[9:1]};
      if (bit_cnt == 4'd9) tx_busy <= 1'b0; // end of stop bit
      else                 bit_cnt <= bit_cnt + 1'b1;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
// 8N1 only, no parity or framing flags; a bad stop bit just drops the byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx import life_pkg::*; (
  input  wire   clk,
  input  wire   boot_reset,
  input  wire   rx,
  output byte_t rx_data,
  output logic  rx_valid
);

  typedef enum logic [1:0] {rxs_idle, rxs_start, rxs_data, rxs_stop} rx_state_t;

  rx_state_t state;
  logic      rx_meta, rx_sync, rx_prev; // two-flop sync plus edge history
  baud_cnt_t baud_cnt;
  logic [2:0] bit_cnt;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      rx_meta  <= 1'b1; // line idles high
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= rxs_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      case (state)
        rxs_idle: if (rx_prev && !rx_sync) begin // falling start edge
          state    <= rxs_start;
          baud_cnt <= '0;
        end
        rxs_start: begin
          if (baud_cnt == baud_cnt_t'(clks_per_bit / 2 - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? rxs_idle : rxs_data; // glitch guard
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rxs_data: begin
          if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin // middle of a data bit
            baud_cnt <= '0;
            rx_data  <= {rx_sync, rx_data[7:1]};             // lsb arrives first
            if (bit_cnt == 3'd7) state <= rxs_stop;
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin // rxs_stop
          if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
            state    <= rxs_idle;
            rx_valid <= rx_sync; // only with a good stop bit
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/board_if.sv
// no clock inside; strobes and done are single-cycle and only meaningful in the clk domain
`timescale 1ns/1ps
`default_nettype none

interface board_if import life_pkg::*; ();

  logic        fill_start; // start random fill
  logic        step_start; // start one generation
  logic        done;       // action finished
  cell_index_t rd_index;   // printer read address
  logic        rd_cell;    // current state at rd_index, combinational

  modport engine (input fill_start, step_start, rd_index, output done, rd_cell);
  modport ctrl   (output fill_start, step_start, input done);
  modport reader (output rd_index, input rd_cell);

endinterface

`default_nettype wire

// File: hdl/life_pkg.sv
// fixed 8x8 board; uart timing assumes a 10 MHz clock at 115200 baud, change clks_per_bit otherwise
`default_nettype none

package life_pkg;

  // board geometry, powers of two so cell indices wrap for free
  localparam int log_width   = 3;
  localparam int log_height  = 3;
  localparam int board_width = 1 << log_width;
  localparam int board_cells = board_width * (1 << log_height);

  typedef logic [log_width+log_height-1:0] cell_index_t; // {row, col}
  typedef logic [board_cells-1:0]          board_t;      // bit n is cell n
  typedef logic [7:0]                      byte_t;
  typedef logic [15:0]                     lfsr_t;

  localparam int clks_per_bit = 87;                      // 10 MHz / 115200
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

  // printed characters
  localparam byte_t char_alive = 8'h4f;                  // 'O'
  localparam byte_t char_dead  = 8'h20;                  // space
  localparam byte_t char_cr    = 8'h0d;
  localparam byte_t char_lf    = 8'h0a;

  // ansi cursor home: ESC [ ; H
  localparam int    home_seq_len = 4;
  localparam byte_t home_seq [home_seq_len] = '{8'h1b, 8'h5b, 8'h3b, 8'h48};

  localparam byte_t cmd_random = 8'h30;                  // '0'
  localparam byte_t cmd_step   = 8'h31;                  // '1'
  localparam lfsr_t lfsr_seed  = 16'hace1;

  typedef enum logic [1:0] {ctrl_idle, ctrl_fill, ctrl_update, ctrl_print} ctrl_state_t;
  typedef enum logic [1:0] {prt_home, prt_cell, prt_line_end, prt_wait_busy} print_state_t;
  typedef enum logic [1:0] {eng_idle, eng_fill, eng_count, eng_copy} engine_state_t;

endpackage

`default_nettype wire
